// ==== cpu_controller.f ====
isa_pkg.sv
ctrl_pkg.sv
cycle_sequencer.sv
instr_decode.sv
operand_ctrl.sv
pc_mem_wb_ctrl.sv
cpu_controller.sv
tb_cpu_controller.sv

// ==== cpu_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_controller
    import ctrl_pkg::*;
    import isa_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire opcode_t opcode,
    input  wire cond_t   cond,
    input  wire status_t status_reg,
    input  wire logic    P,
    input  wire logic    U,
    input  wire logic    W,
    input  wire logic    en_status_decode,
    // instruction register and status
    output logic         load_ir,
    output logic         status_rdy,
    // operand registers
    output logic         en_A,
    output logic         en_B,
    output logic         en_S,
    output operand_sel_t sel_A_in,
    output operand_sel_t sel_shift_in,
    output logic         sel_shift,
    // pc and alu
    output logic         load_pc,
    output pc_sel_t      sel_pc,
    output alu_op_t      alu_op,
    output logic         sel_A,
    output logic         sel_B,
    output logic         sel_post_indexing,
    output logic         en_C,
    output logic         en_status,
    // register file and ram
    output logic         w_en1,
    output logic         w_en2,
    output logic         sel_w_addr1,
    output logic         ram_w_en2,
    output logic         w_en3
);

    ctrl_state_t state;
    logic        is_alu;
    logic        is_mem;
    logic        is_load;
    logic        is_branch;
    logic        cond_pass;

    cycle_sequencer cycle_sequencer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .load_ir    (load_ir),
        .status_rdy (status_rdy)
    );

    instr_decode instr_decode_inst (
        .opcode     (opcode),
        .cond       (cond),
        .status_reg (status_reg),
        .is_alu     (is_alu),
        .is_mem     (is_mem),
        .is_load    (is_load),
        .is_branch  (is_branch),
        .cond_pass  (cond_pass)
    );

    operand_ctrl operand_ctrl_inst (
        .state        (state),
        .opcode       (opcode),
        .is_alu       (is_alu),
        .is_mem       (is_mem),
        .is_branch    (is_branch),
        .en_A         (en_A),
        .en_B         (en_B),
        .en_S         (en_S),
        .sel_A_in     (sel_A_in),
        .sel_shift_in (sel_shift_in),
        .sel_shift    (sel_shift)
    );

    pc_mem_wb_ctrl pc_mem_wb_ctrl_inst (
        .state             (state),
        .opcode            (opcode),
        .P                 (P),
        .U                 (U),
        .W                 (W),
        .en_status_decode  (en_status_decode),
        .is_alu            (is_alu),
        .is_mem            (is_mem),
        .is_load           (is_load),
        .is_branch         (is_branch),
        .cond_pass         (cond_pass),
        .load_pc           (load_pc),
        .sel_pc            (sel_pc),
        .alu_op            (alu_op),
        .sel_A             (sel_A),
        .sel_B             (sel_B),
        .sel_post_indexing (sel_post_indexing),
        .en_C              (en_C),
        .en_status         (en_status),
        .w_en1             (w_en1),
        .w_en2             (w_en2),
        .sel_w_addr1       (sel_w_addr1),
        .ram_w_en2         (ram_w_en2),
        .w_en3             (w_en3)
    );

endmodule

`default_nettype wire

// ==== ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    // instruction cycle, start state only once after reset
    typedef enum logic [3:0] {
        st_reset         = 4'd0,
        st_load_pc_start = 4'd8,
        st_fetch         = 4'd1,
        st_fetch_wait    = 4'd2,
        st_decode        = 4'd3,
        st_execute       = 4'd4,
        st_memory        = 4'd5,
        st_memory_wait   = 4'd6,
        st_write_back    = 4'd7
    } ctrl_state_t;

    typedef logic [2:0] alu_op_t;
    localparam alu_op_t ALU_ADD = 3'b000;
    localparam alu_op_t ALU_SUB = 3'b001;
    localparam alu_op_t ALU_AND = 3'b010;
    localparam alu_op_t ALU_ORR = 3'b011;
    localparam alu_op_t ALU_XOR = 3'b111;

    // pc source mux
    typedef logic [1:0] pc_sel_t;
    localparam pc_sel_t PC_SEL_INC    = 2'b00;
    localparam pc_sel_t PC_SEL_VECTOR = 2'b01;
    localparam pc_sel_t PC_SEL_BRANCH = 2'b11;

    // operand source muxes
    typedef logic [1:0] operand_sel_t;
    localparam operand_sel_t SRC_REG          = 2'b00;
    localparam operand_sel_t SRC_PC_OR_TARGET = 2'b11;

endpackage

`default_nettype wire

// ==== cycle_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cycle_sequencer
    import ctrl_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    output ctrl_state_t state,
    output logic        load_ir,
    output logic        status_rdy
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_reset;
        end else begin
            case (state)
                st_reset:         state <= st_load_pc_start;
                st_load_pc_start: state <= st_fetch;
                st_fetch:         state <= st_fetch_wait;
                st_fetch_wait:    state <= st_decode;
                st_decode:        state <= st_execute;
                st_execute:       state <= st_memory;
                st_memory:        state <= st_memory_wait;
                st_memory_wait:   state <= st_write_back;
                // back to fetch, the vector load is not repeated
                st_write_back:    state <= st_fetch;
                default:          state <= st_reset;
            endcase
        end
    end

    // instruction word is stable on the ram output by now
    assign load_ir = (state == st_decode);

    // flags from the memory cycle are settled one state later
    assign status_rdy = (state == st_memory_wait);

    a_decode_after_fetch_wait: assert property (
        @(posedge clk) disable iff (!rst_n)
        state == st_fetch_wait |=> state == st_decode
    );

endmodule

`default_nettype wire

// ==== instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode
    import ctrl_pkg::*;
    import isa_pkg::*;
(
    input  wire opcode_t opcode,
    input  wire cond_t   cond,
    input  wire status_t status_reg,
    output logic         is_alu,
    output logic         is_mem,
    output logic         is_load,
    output logic         is_branch,
    output logic         cond_pass
);

    logic flag_n;
    logic flag_z;
    logic flag_c;
    logic flag_v;

    assign flag_n = status_reg[FLAG_N_BIT];
    assign flag_z = status_reg[FLAG_Z_BIT];
    assign flag_c = status_reg[FLAG_C_BIT];
    assign flag_v = status_reg[FLAG_V_BIT];

    // families in priority order
    assign is_alu    = !opcode[6] && (cond != COND_NEVER);
    assign is_mem    = !is_alu && ((opcode[6:5] == OPC_MEM_HI) || (opcode[6:3] == OPC_LIT_LOAD));
    assign is_branch = !is_alu && !is_mem && (opcode[6:3] == OPC_BRANCH);

    // register loads plus the literal load
    assign is_load = (opcode[6:4] == OPC_LOAD_HI) || (opcode[6:3] == OPC_LIT_LOAD);

    always_comb begin
        case (cond)
            COND_EQ: cond_pass = flag_z;
            COND_NE: cond_pass = !flag_z;
            COND_CS: cond_pass = flag_c;
            COND_CC: cond_pass = !flag_c;
            COND_MI: cond_pass = flag_n;
            COND_PL: cond_pass = !flag_n;
            COND_VS: cond_pass = flag_v;
            COND_VC: cond_pass = !flag_v;
            COND_HI: cond_pass = flag_c && !flag_z;
            COND_LS: cond_pass = !flag_c || flag_z;
            COND_GE: cond_pass = (flag_n == flag_v);
            COND_LT: cond_pass = (flag_n != flag_v);
            COND_GT: cond_pass = !flag_z && (flag_n == flag_v);
            COND_LE: cond_pass = flag_z || (flag_n != flag_v);
            COND_AL: cond_pass = 1'b1;
            // never
            default: cond_pass = 1'b0;
        endcase
    end

    always_comb begin
        a_one_family: assert final ($onehot0({is_alu, is_mem, is_branch}));
    end

endmodule

`default_nettype wire

// ==== isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // instruction word fields
    typedef logic [6:0]  opcode_t;
    typedef logic [3:0]  cond_t;
    typedef logic [31:0] status_t;

    // flag positions in the status word
    localparam int FLAG_N_BIT = 31;
    localparam int FLAG_Z_BIT = 30;
    localparam int FLAG_C_BIT = 29;
    localparam int FLAG_V_BIT = 28;

    // condition codes
    localparam cond_t COND_EQ    = 4'b0000;
    localparam cond_t COND_NE    = 4'b0001;
    localparam cond_t COND_CS    = 4'b0010;
    localparam cond_t COND_CC    = 4'b0011;
    localparam cond_t COND_MI    = 4'b0100;
    localparam cond_t COND_PL    = 4'b0101;
    localparam cond_t COND_VS    = 4'b0110;
    localparam cond_t COND_VC    = 4'b0111;
    localparam cond_t COND_HI    = 4'b1000;
    localparam cond_t COND_LS    = 4'b1001;
    localparam cond_t COND_GE    = 4'b1010;
    localparam cond_t COND_LT    = 4'b1011;
    localparam cond_t COND_GT    = 4'b1100;
    localparam cond_t COND_LE    = 4'b1101;
    localparam cond_t COND_AL    = 4'b1110;
    // also marks a non-ALU encoding when opcode bit 6 is clear
    localparam cond_t COND_NEVER = 4'b1111;

    // opcode prefixes of the instruction families
    localparam logic [1:0] OPC_MEM_HI   = 2'b11;
    localparam logic [2:0] OPC_LOAD_HI  = 3'b110;
    localparam logic [2:0] OPC_LIT_HI   = 3'b100;
    localparam logic [3:0] OPC_LIT_LOAD = 4'b1000;
    localparam logic [3:0] OPC_BRANCH   = 4'b1001;
    localparam logic [3:0] OPC_CMP_LOW  = 4'b1010;

endpackage

`default_nettype wire

// ==== operand_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_ctrl
    import ctrl_pkg::*;
    import isa_pkg::*;
(
    input  wire ctrl_state_t state,
    input  wire opcode_t     opcode,
    input  wire logic        is_alu,
    input  wire logic        is_mem,
    input  wire logic        is_branch,
    output logic             en_A,
    output logic             en_B,
    output logic             en_S,
    output operand_sel_t     sel_A_in,
    output operand_sel_t     sel_shift_in,
    output logic             sel_shift
);

    always_comb begin
        en_A         = 1'b0;
        en_B         = 1'b0;
        en_S         = 1'b0;
        sel_A_in     = SRC_REG;
        sel_shift_in = SRC_REG;
        sel_shift    = 1'b0;

        if (state == st_execute) begin
            if (is_alu) begin
                en_A = opcode[3];
                en_B = opcode[4];
                en_S = 1'b1;
                // shift amount only with a register operand
                sel_shift = opcode[4] ? opcode[5] : 1'b0;
            end else if (is_mem) begin
                en_A = 1'b1;
                if (opcode[3]) begin
                    // register offset from Rm
                    en_B = 1'b1;
                    en_S = 1'b1;
                end else if (opcode[6:4] == OPC_LIT_HI) begin
                    // literal load, base is the pc
                    sel_A_in = SRC_PC_OR_TARGET;
                end
            end else if (is_branch) begin
                en_B         = opcode[1];
                en_S         = 1'b1;
                sel_shift    = 1'b1;
                sel_shift_in = SRC_PC_OR_TARGET;
            end
        end
    end

endmodule

`default_nettype wire

// ==== pc_mem_wb_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_mem_wb_ctrl
    import ctrl_pkg::*;
    import isa_pkg::*;
(
    input  wire ctrl_state_t state,
    input  wire opcode_t     opcode,
    input  wire logic        P,
    input  wire logic        U,
    input  wire logic        W,
    input  wire logic        en_status_decode,
    input  wire logic        is_alu,
    input  wire logic        is_mem,
    input  wire logic        is_load,
    input  wire logic        is_branch,
    input  wire logic        cond_pass,
    output logic             load_pc,
    output pc_sel_t          sel_pc,
    output alu_op_t          alu_op,
    output logic             sel_A,
    output logic             sel_B,
    output logic             sel_post_indexing,
    output logic             en_C,
    output logic             en_status,
    output logic             w_en1,
    output logic             w_en2,
    output logic             sel_w_addr1,
    output logic             ram_w_en2,
    output logic             w_en3
);

    always_comb begin
        load_pc           = 1'b0;
        sel_pc            = PC_SEL_INC;
        alu_op            = ALU_ADD;
        sel_A             = 1'b0;
        sel_B             = 1'b0;
        sel_post_indexing = 1'b0;
        en_C              = 1'b0;
        en_status         = 1'b0;
        w_en1             = 1'b0;
        w_en2             = 1'b0;
        sel_w_addr1       = 1'b0;
        ram_w_en2         = 1'b0;
        w_en3             = 1'b0;

        case (state)
            st_load_pc_start: begin
                load_pc = 1'b1;
                sel_pc  = PC_SEL_VECTOR;
            end
            st_memory: begin
                en_C = 1'b1;
                if (is_alu) begin
                    load_pc = 1'b1;
                    case (opcode[2:0])
                        3'b000:  alu_op = ALU_ADD;
                        3'b001:  alu_op = ALU_SUB;
                        3'b010:  alu_op = ALU_SUB;
                        3'b011:  alu_op = ALU_AND;
                        3'b100:  alu_op = ALU_ORR;
                        3'b101:  alu_op = ALU_XOR;
                        default: alu_op = ALU_ADD;
                    endcase
                    // immediate path when the operand register is not loaded
                    sel_A     = !opcode[3];
                    sel_B     = !opcode[4];
                    en_status = en_status_decode;
                    // compare only updates the flags
                    w_en1     = (opcode[3:0] != OPC_CMP_LOW);
                end else if (is_mem) begin
                    load_pc           = 1'b1;
                    alu_op            = U ? ALU_ADD : ALU_SUB;
                    sel_B             = !opcode[3];
                    sel_post_indexing = !P;
                    en_status         = en_status_decode;
                    // base write-back, always on post-indexing
                    w_en2             = !P || W;
                    ram_w_en2         = opcode[4];
                end else if (is_branch) begin
                    load_pc     = 1'b1;
                    sel_pc      = cond_pass ? PC_SEL_BRANCH : PC_SEL_INC;
                    sel_A       = 1'b1;
                    sel_B       = !opcode[1];
                    // link register write
                    w_en1       = opcode[2];
                    sel_w_addr1 = opcode[2];
                end
            end
            st_write_back: begin
                w_en3 = is_load;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        a_no_store_and_reg_write: assert final (!(ram_w_en2 && w_en1));
        a_load_pc_states: assert final (
            !load_pc || state == st_load_pc_start || state == st_memory
        );
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cpu_controller testbench with verilator
rm -f sim.log && \
verilator --binary --timing --assert -f cpu_controller.f --top-module tb_cpu_controller \
    -o sim_cpu_controller > build.log 2>&1 && \
./obj_dir/sim_cpu_controller > sim.log 2>&1
grep -q "Simulation passed" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

// ==== tb_cpu_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_controller
    import ctrl_pkg::*;
    import isa_pkg::*;
();

    localparam int NUM_INSTR = 200;
    // room for 220 instructions of 7 cycles plus reset
    localparam int TIMEOUT_CYCLES = 1600;

    typedef struct packed {
        logic         load_ir;
        logic         status_rdy;
        logic         en_A;
        logic         en_B;
        logic         en_S;
        operand_sel_t sel_A_in;
        operand_sel_t sel_shift_in;
        logic         sel_shift;
        logic         load_pc;
        pc_sel_t      sel_pc;
        alu_op_t      alu_op;
        logic         sel_A;
        logic         sel_B;
        logic         sel_post_indexing;
        logic         en_C;
        logic         en_status;
        logic         w_en1;
        logic         w_en2;
        logic         sel_w_addr1;
        logic         ram_w_en2;
        logic         w_en3;
    } ctrl_out_t;

    logic         clk;
    logic         rst_n;
    opcode_t      opcode;
    cond_t        cond;
    status_t      status_reg;
    logic         P;
    logic         U;
    logic         W;
    logic         en_status_decode;
    logic         load_ir;
    logic         status_rdy;
    logic         en_A;
    logic         en_B;
    logic         en_S;
    operand_sel_t sel_A_in;
    operand_sel_t sel_shift_in;
    logic         sel_shift;
    logic         load_pc;
    pc_sel_t      sel_pc;
    alu_op_t      alu_op;
    logic         sel_A;
    logic         sel_B;
    logic         sel_post_indexing;
    logic         en_C;
    logic         en_status;
    logic         w_en1;
    logic         w_en2;
    logic         sel_w_addr1;
    logic         ram_w_en2;
    logic         w_en3;

    // -2 reset, -1 vector load, 0 to 6 fetch through write back
    int           ref_phase = -2;
    string        test_name = "reset";
    logic [31:0]  seed_value;

    cpu_controller cpu_controller_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .opcode            (opcode),
        .cond              (cond),
        .status_reg        (status_reg),
        .P                 (P),
        .U                 (U),
        .W                 (W),
        .en_status_decode  (en_status_decode),
        .load_ir           (load_ir),
        .status_rdy        (status_rdy),
        .en_A              (en_A),
        .en_B              (en_B),
        .en_S              (en_S),
        .sel_A_in          (sel_A_in),
        .sel_shift_in      (sel_shift_in),
        .sel_shift         (sel_shift),
        .load_pc           (load_pc),
        .sel_pc            (sel_pc),
        .alu_op            (alu_op),
        .sel_A             (sel_A),
        .sel_B             (sel_B),
        .sel_post_indexing (sel_post_indexing),
        .en_C              (en_C),
        .en_status         (en_status),
        .w_en1             (w_en1),
        .w_en2             (w_en2),
        .sel_w_addr1       (sel_w_addr1),
        .ram_w_en2         (ram_w_en2),
        .w_en3             (w_en3)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic cond_holds(input cond_t cd, input status_t st);
        logic n;
        logic z;
        logic c;
        logic v;
        n = st[FLAG_N_BIT];
        z = st[FLAG_Z_BIT];
        c = st[FLAG_C_BIT];
        v = st[FLAG_V_BIT];
        case (cd)
            4'b0000: return z;
            4'b0001: return !z;
            4'b0010: return c;
            4'b0011: return !c;
            4'b0100: return n;
            4'b0101: return !n;
            4'b0110: return v;
            4'b0111: return !v;
            4'b1000: return c && !z;
            4'b1001: return !c || z;
            4'b1010: return n == v;
            4'b1011: return n != v;
            4'b1100: return !z && (n == v);
            4'b1101: return z || (n != v);
            4'b1110: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic ctrl_out_t expected_ctrl(input int phase, input opcode_t op,
            input cond_t cd, input status_t st, input logic p, input logic u,
            input logic w, input logic esd);
        ctrl_out_t e;
        logic      alu;
        logic      mem;
        logic      br;
        logic      ld;
        e   = '0;
        alu = !op[6] && (cd != 4'b1111);
        mem = !alu && ((op[6:5] == 2'b11) || (op[6:3] == 4'b1000));
        br  = !alu && !mem && (op[6:3] == 4'b1001);
        ld  = (op[6:4] == 3'b110) || (op[6:3] == 4'b1000);
        case (phase)
            -1: begin
                e.load_pc = 1'b1;
                e.sel_pc  = PC_SEL_VECTOR;
            end
            2: e.load_ir = 1'b1;
            3: begin
                if (alu) begin
                    e.en_A      = op[3];
                    e.en_B      = op[4];
                    e.en_S      = 1'b1;
                    e.sel_shift = op[4] && op[5];
                end else if (mem) begin
                    e.en_A = 1'b1;
                    e.en_B = op[3];
                    e.en_S = op[3];
                    // literal load takes the pc as base
                    if (!op[3] && op[6:4] == 3'b100) begin
                        e.sel_A_in = SRC_PC_OR_TARGET;
                    end
                end else if (br) begin
                    e.en_B         = op[1];
                    e.en_S         = 1'b1;
                    e.sel_shift    = 1'b1;
                    e.sel_shift_in = SRC_PC_OR_TARGET;
                end
            end
            4: begin
                e.en_C = 1'b1;
                if (alu) begin
                    e.load_pc = 1'b1;
                    case (op[2:0])
                        3'b001, 3'b010: e.alu_op = ALU_SUB;
                        3'b011:         e.alu_op = ALU_AND;
                        3'b100:         e.alu_op = ALU_ORR;
                        3'b101:         e.alu_op = ALU_XOR;
                        default:        e.alu_op = ALU_ADD;
                    endcase
                    e.sel_A     = !op[3];
                    e.sel_B     = !op[4];
                    e.en_status = esd;
                    e.w_en1     = (op[3:0] != OPC_CMP_LOW);
                end else if (mem) begin
                    e.load_pc           = 1'b1;
                    e.alu_op            = u ? ALU_ADD : ALU_SUB;
                    e.sel_B             = !op[3];
                    e.sel_post_indexing = !p;
                    e.en_status         = esd;
                    e.w_en2             = !p || w;
                    e.ram_w_en2         = op[4];
                end else if (br) begin
                    e.load_pc     = 1'b1;
                    e.sel_pc      = cond_holds(cd, st) ? PC_SEL_BRANCH : PC_SEL_INC;
                    e.sel_A       = 1'b1;
                    e.sel_B       = !op[1];
                    e.w_en1       = op[2];
                    e.sel_w_addr1 = op[2];
                end
            end
            5: e.status_rdy = 1'b1;
            6: e.w_en3 = ld;
            default: begin
            end
        endcase
        return e;
    endfunction

    task automatic check_bit(input string sig, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("[FAIL] %s: %s expected %b, actual %b", test_name, sig, exp_v, act_v);
            $display("Simulation failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic check_alu_op(input string sig, input alu_op_t exp_v, input alu_op_t act_v);
        if (act_v !== exp_v) begin
            $display("[FAIL] %s: %s expected %b, actual %b", test_name, sig, exp_v, act_v);
            $display("Simulation failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic check_pc_sel(input string sig, input pc_sel_t exp_v, input pc_sel_t act_v);
        if (act_v !== exp_v) begin
            $display("[FAIL] %s: %s expected %b, actual %b", test_name, sig, exp_v, act_v);
            $display("Simulation failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic check_operand_sel(input string sig, input operand_sel_t exp_v,
            input operand_sel_t act_v);
        if (act_v !== exp_v) begin
            $display("[FAIL] %s: %s expected %b, actual %b", test_name, sig, exp_v, act_v);
            $display("Simulation failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic compare_outputs(input ctrl_out_t e);
        check_bit("load_ir", e.load_ir, load_ir);
        check_bit("status_rdy", e.status_rdy, status_rdy);
        check_bit("en_A", e.en_A, en_A);
        check_bit("en_B", e.en_B, en_B);
        check_bit("en_S", e.en_S, en_S);
        check_operand_sel("sel_A_in", e.sel_A_in, sel_A_in);
        check_operand_sel("sel_shift_in", e.sel_shift_in, sel_shift_in);
        check_bit("sel_shift", e.sel_shift, sel_shift);
        check_bit("load_pc", e.load_pc, load_pc);
        check_pc_sel("sel_pc", e.sel_pc, sel_pc);
        check_alu_op("alu_op", e.alu_op, alu_op);
        check_bit("sel_A", e.sel_A, sel_A);
        check_bit("sel_B", e.sel_B, sel_B);
        check_bit("sel_post_indexing", e.sel_post_indexing, sel_post_indexing);
        check_bit("en_C", e.en_C, en_C);
        check_bit("en_status", e.en_status, en_status);
        check_bit("w_en1", e.w_en1, w_en1);
        check_bit("w_en2", e.w_en2, w_en2);
        check_bit("sel_w_addr1", e.sel_w_addr1, sel_w_addr1);
        check_bit("ram_w_en2", e.ram_w_en2, ram_w_en2);
        check_bit("w_en3", e.w_en3, w_en3);
    endtask

    // outputs sampled at the rising edge, before the state moves on
    initial begin
        ctrl_out_t exp_out;
        @(negedge clk);
        forever begin
            @(posedge clk);
            exp_out = expected_ctrl(ref_phase, opcode, cond, status_reg, P, U, W,
                                    en_status_decode);
            compare_outputs(exp_out);
            if (!rst_n) begin
                ref_phase = -2;
            end else if (ref_phase == 6) begin
                ref_phase = 0;
            end else begin
                ref_phase = ref_phase + 1;
            end
        end
    end

    task automatic wait_for_fetch();
        @(negedge clk);
        while (ref_phase != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic drive_instr(input int n);
        logic [31:0] r;
        r                = $urandom;
        status_reg       = $urandom;
        P                = r[0];
        U                = r[1];
        W                = r[2];
        en_status_decode = r[3];
        cond             = r[20:17];
        if (n < 60) begin
            test_name = "alu";
            opcode    = {1'b0, r[9:4]};
            cond      = cond_t'($urandom_range(14, 0));
        end else if (n < 120) begin
            test_name = "load_store";
            // one in four is the literal load
            if (r[11:10] == 2'b00) begin
                opcode = {4'b1000, r[14:12]};
            end else begin
                opcode = {2'b11, r[16:12]};
            end
        end else if (n < 180) begin
            test_name = "branch";
            opcode    = {4'b1001, r[14:12]};
        end else begin
            test_name = "unclassified";
            if (r[11]) begin
                opcode = {3'b101, r[15:12]};
            end else begin
                opcode = {1'b0, r[17:12]};
                cond   = 4'b1111;
            end
        end
    endtask

    initial begin
        seed_value       = $urandom(32'h24c1_754b);
        rst_n            = 1'b0;
        opcode           = '0;
        cond             = '0;
        status_reg       = '0;
        P                = 1'b0;
        U                = 1'b0;
        W                = 1'b0;
        en_status_decode = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        for (int n = 0; n < NUM_INSTR; n++) begin
            wait_for_fetch();
            drive_instr(n);
        end
        // last write back checked once the next fetch starts
        wait_for_fetch();
        $display("Simulation passed");
        $finish;
    end

    initial begin
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire
